//--- files.f
+incdir+dv
source/be_calc_pkg.sv
source/be_calc_issue.sv
source/be_calc_pipe_int.sv
source/be_calc_pipe_mul.sv
source/be_calc_exc_pipe.sv
source/be_calc_comp_pipe.sv
source/be_calc_top.sv
dv/tb_be_calc.sv

//--- Bender.yml
package:
  name: be_calc

sources:
  - files:
      - source/be_calc_pkg.sv
      - source/be_calc_issue.sv
      - source/be_calc_pipe_int.sv
      - source/be_calc_pipe_mul.sv
      - source/be_calc_exc_pipe.sv
      - source/be_calc_comp_pipe.sv
      - source/be_calc_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_be_calc.sv

//--- dv/be_calc_model.svh
// Reference model: registers, operation results, flush rule and per-cycle expected outputs
`ifndef BE_CALC_MODEL_SVH
`define BE_CALC_MODEL_SVH

localparam int max_cycles_lp = 1024;

dword_t    model_regs [32];
int        squash_until;

// Branch report per cycle: 0 idle, 1 checked, 2 squashed and not checked
int        exp_br_kind    [max_cycles_lp];
bit        exp_br_taken   [max_cycles_lp];
vaddr_t    exp_br_npc     [max_cycles_lp];
bit        exp_cm_v       [max_cycles_lp];
bit        exp_cm_instret [max_cycles_lp];
bit        exp_cm_npc_w_v [max_cycles_lp];
bit        exp_cm_exc     [max_cycles_lp];
vaddr_t    exp_cm_npc     [max_cycles_lp];
bit        exp_wb_v       [max_cycles_lp];
reg_addr_t exp_wb_addr    [max_cycles_lp];
dword_t    exp_wb_data    [max_cycles_lp];

task automatic model_init();
  for (int i = 0; i < 32; i++)
    model_regs[i] = '0;
  squash_until = -1;
endtask

function automatic dword_t op_result(input calc_op_e op, input dword_t a, input dword_t b,
                                     input vaddr_t pc);
  case (op)
    e_op_add: return a + b;
    e_op_sub: return a - b;
    e_op_and: return a & b;
    e_op_or:  return a | b;
    e_op_xor: return a ^ b;
    e_op_sll: return a << b[4:0];
    e_op_srl: return a >> b[4:0];
    e_op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    e_op_mul: return a * b;
    e_op_jal: return pc + 32'd4;
    default:  return '0;
  endcase
endfunction

// Program order: an older redirect decides whether this dispatch survives
task automatic model_dispatch(input int cyc, input calc_op_e op, input vaddr_t pc,
                              input reg_addr_t rs1, input reg_addr_t rs2, input reg_addr_t rd,
                              input dword_t imm, input bit use_imm, input bit rd_w,
                              input bit illegal);
  dword_t a;
  dword_t s2;
  bit     taken;
  vaddr_t npc;
  if (cyc <= squash_until)
    begin
      // The dispatch in the redirect cycle never reaches the reservation register
      exp_br_kind[cyc+1] = (cyc == squash_until) ? 0 : 2;
    end
  else
    begin
      a     = model_regs[rs1];
      s2    = model_regs[rs2];
      taken = (op == e_op_jal) || (op == e_op_beq && a == s2) || (op == e_op_bne && a != s2);
      npc   = taken ? pc + imm : pc + 32'd4;
      exp_br_kind[cyc+1]    = 1;
      exp_br_taken[cyc+1]   = taken;
      exp_br_npc[cyc+1]     = npc;
      exp_cm_v[cyc+3]       = 1'b1;
      exp_cm_instret[cyc+3] = !illegal;
      exp_cm_exc[cyc+3]     = illegal;
      exp_cm_npc_w_v[cyc+3] = illegal || taken;
      exp_cm_npc[cyc+3]     = illegal ? pc : npc;
      if (rd_w && !illegal)
        begin
          exp_wb_v[cyc+4]    = 1'b1;
          exp_wb_addr[cyc+4] = rd;
          exp_wb_data[cyc+4] = op_result(op, a, use_imm ? imm : s2, pc);
          if (rd != '0)
            model_regs[rd] = exp_wb_data[cyc+4];
        end
      if (illegal || taken)
        squash_until = cyc + 3;
    end
endtask

`endif

//--- dv/tb_be_calc.sv
// Testbench for the calculator back end: clock, reset, random stimulus, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_be_calc
  import be_calc_pkg::*;
  ();

  localparam int n_alu_lp  = 40;
  localparam int n_dep_lp  = 30;
  localparam int n_mul_lp  = 30;
  localparam int n_br_lp   = 30;
  localparam int n_exc_lp  = 20;
  localparam int n_idle_lp = 6;
  // Idle drain slots count as dispatches too
  localparam int total_dispatch_lp = n_alu_lp + n_dep_lp + n_mul_lp + n_br_lp + n_exc_lp
                                     + 6 * n_idle_lp;

  logic      clk;
  logic      rst_n;
  logic      dispatch_v;
  calc_op_e  dispatch_op;
  vaddr_t    dispatch_pc;
  dword_t    dispatch_rs1, dispatch_rs2, dispatch_imm;
  logic      dispatch_use_imm;
  reg_addr_t dispatch_rs1_addr, dispatch_rs2_addr, dispatch_rd_addr;
  logic      dispatch_rs1_r_v, dispatch_rs2_r_v, dispatch_rd_w_v, dispatch_illegal;
  logic      br_v, br_taken;
  vaddr_t    br_npc;
  logic      commit_v, commit_instret, commit_npc_w_v, commit_exc;
  vaddr_t    commit_npc;
  logic      iwb_v;
  reg_addr_t iwb_addr;
  dword_t    iwb_data;

  // Architectural register file as seen by dispatch, updated only from writeback
  dword_t    rf [32];
  int        last_wr [32];
  int        busy_until [32];
  int        cyc;
  vaddr_t    pc;
  reg_addr_t last_rd;
  reg_addr_t last_mul_rd;
  int        errors;
  int        tests_run;
  int        tests_failed;
  int        test_start_errors;
  string     test_name;

  `include "be_calc_model.svh"

  be_calc_top i_be_calc_top
    (.clk_i(clk), .rst_n_i(rst_n)
     , .dispatch_v_i(dispatch_v), .dispatch_op_i(dispatch_op), .dispatch_pc_i(dispatch_pc)
     , .dispatch_rs1_i(dispatch_rs1), .dispatch_rs2_i(dispatch_rs2)
     , .dispatch_imm_i(dispatch_imm), .dispatch_use_imm_i(dispatch_use_imm)
     , .dispatch_rs1_addr_i(dispatch_rs1_addr), .dispatch_rs2_addr_i(dispatch_rs2_addr)
     , .dispatch_rd_addr_i(dispatch_rd_addr)
     , .dispatch_rs1_r_v_i(dispatch_rs1_r_v), .dispatch_rs2_r_v_i(dispatch_rs2_r_v)
     , .dispatch_rd_w_v_i(dispatch_rd_w_v), .dispatch_illegal_i(dispatch_illegal)
     , .br_v_o(br_v), .br_taken_o(br_taken), .br_npc_o(br_npc)
     , .commit_v_o(commit_v), .commit_instret_o(commit_instret)
     , .commit_npc_w_v_o(commit_npc_w_v), .commit_npc_o(commit_npc), .commit_exc_o(commit_exc)
     , .iwb_v_o(iwb_v), .iwb_addr_o(iwb_addr), .iwb_data_o(iwb_data)
     );

  initial
    begin
      clk = 1'b0;
      forever
        #5 clk = ~clk;
    end

  initial
    begin
      repeat (total_dispatch_lp * 10)
        @(posedge clk);
      $display("Watchdog expired before all tests finished at cycle %0d", cyc);
      $display("sim failed");
      $finish;
    end

  task automatic check_branch(input bit exp_v, input bit exp_taken, input vaddr_t exp_npc);
    if (br_v !== exp_v)
      begin
        $display("** Error %s: cycle %0d br_v expected %0b actual %b", test_name, cyc, exp_v, br_v);
        errors++;
      end
    else if (exp_v && (br_taken !== exp_taken || br_npc !== exp_npc))
      begin
        $display("** Error %s: cycle %0d branch expected taken %0b npc %h actual taken %b npc %h",
                 test_name, cyc, exp_taken, exp_npc, br_taken, br_npc);
        errors++;
      end
  endtask

  task automatic check_commit(input bit exp_v, input bit exp_instret, input bit exp_npc_w_v,
                              input bit exp_exc, input vaddr_t exp_npc);
    if (commit_v !== exp_v)
      begin
        $display("** Error %s: cycle %0d commit_v expected %0b actual %b",
                 test_name, cyc, exp_v, commit_v);
        errors++;
      end
    else if (exp_v && ({commit_instret, commit_npc_w_v, commit_exc}
                       !== {exp_instret, exp_npc_w_v, exp_exc} || commit_npc !== exp_npc))
      begin
        $display("** Error %s: cycle %0d commit ret/redir/exc npc expected %b%b%b %h actual %b%b%b %h",
                 test_name, cyc, exp_instret, exp_npc_w_v, exp_exc, exp_npc,
                 commit_instret, commit_npc_w_v, commit_exc, commit_npc);
        errors++;
      end
  endtask

  task automatic check_wb(input bit exp_v, input reg_addr_t exp_addr, input dword_t exp_data);
    if (iwb_v !== exp_v)
      begin
        $display("** Error %s: cycle %0d iwb_v expected %0b actual %b", test_name, cyc, exp_v, iwb_v);
        errors++;
      end
    else if (exp_v && (iwb_addr !== exp_addr || iwb_data !== exp_data))
      begin
        $display("** Error %s: cycle %0d writeback expected x%0d=%h actual x%0d=%h",
                 test_name, cyc, exp_addr, exp_data, iwb_addr, iwb_data);
        errors++;
      end
  endtask

  task automatic check_cycle();
    if (exp_br_kind[cyc] != 2)
      check_branch(exp_br_kind[cyc] == 1, exp_br_taken[cyc], exp_br_npc[cyc]);
    check_commit(exp_cm_v[cyc], exp_cm_instret[cyc], exp_cm_npc_w_v[cyc], exp_cm_exc[cyc],
                 exp_cm_npc[cyc]);
    check_wb(exp_wb_v[cyc], exp_wb_addr[cyc], exp_wb_data[cyc]);
  endtask

  // Random source that is old enough and not a product still on its way to stage 3
  function automatic reg_addr_t pick_src(input int min_age);
    reg_addr_t r;
    r = reg_addr_t'($urandom_range(31, 0));
    while (cyc - last_wr[r] < min_age || cyc <= busy_until[r])
      r = reg_addr_t'($urandom_range(31, 0));
    return r;
  endfunction

  task automatic send(input bit v, input calc_op_e op, input reg_addr_t rs1,
                      input reg_addr_t rs2, input reg_addr_t rd, input bit rs1_r,
                      input bit rs2_r, input bit rd_w, input bit use_imm, input bit illegal,
                      input dword_t imm);
    @(negedge clk);
    check_cycle();
    if (iwb_v === 1'b1 && iwb_addr != '0)
      rf[iwb_addr] = iwb_data;
    dispatch_v         = v;
    dispatch_op        = op;
    dispatch_pc        = pc;
    dispatch_rs1       = rf[rs1];
    dispatch_rs2       = rf[rs2];
    dispatch_imm       = imm;
    dispatch_use_imm   = use_imm;
    dispatch_rs1_addr  = rs1;
    dispatch_rs2_addr  = rs2;
    dispatch_rd_addr   = rd;
    dispatch_rs1_r_v   = rs1_r;
    dispatch_rs2_r_v   = rs2_r;
    dispatch_rd_w_v    = rd_w;
    dispatch_illegal   = illegal;
    if (v)
      begin
        model_dispatch(cyc, op, pc, rs1, rs2, rd, imm, use_imm, rd_w, illegal);
        if (rd_w)
          last_wr[rd] = cyc;
        // Bypass only carries the product from completion stage 2 on
        if (op == e_op_mul && rd_w)
          busy_until[rd] = cyc + 2;
        pc = pc + 32'd4;
      end
    cyc++;
  endtask

  task automatic send_idle();
    send(1'b0, e_op_add, '0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic send_alu(input reg_addr_t rs1, input reg_addr_t rs2, input bit illegal);
    bit        use_imm;
    reg_addr_t rd;
    use_imm = $urandom_range(1, 0);
    rd      = reg_addr_t'($urandom_range(31, 1));
    send(1'b1, calc_op_e'($urandom_range(7, 0)), rs1, rs2, rd, 1'b1, !use_imm, 1'b1, use_imm,
         illegal, $urandom());
    last_rd = rd;
  endtask

  task automatic send_mul();
    reg_addr_t rs1;
    reg_addr_t rd;
    // Chain on the previous product once the bypass can supply it
    rs1 = (cyc > busy_until[last_mul_rd]) ? last_mul_rd : pick_src(0);
    rd  = reg_addr_t'($urandom_range(31, 1));
    send(1'b1, e_op_mul, rs1, pick_src(0), rd, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, $urandom());
    last_mul_rd = rd;
    last_rd     = rd;
  endtask

  task automatic send_branch_mix();
    int        kind;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    dword_t    offset;
    kind   = $urandom_range(3, 0);
    rs1    = pick_src(0);
    rs2    = $urandom_range(1, 0) ? rs1 : pick_src(0);
    rd     = reg_addr_t'($urandom_range(31, 1));
    offset = dword_t'($urandom_range(255, 1)) << 2;
    case (kind)
      0: send_alu(rs1, rs2, 1'b0);
      1: send(1'b1, e_op_beq, rs1, rs2, '0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, offset);
      2: send(1'b1, e_op_bne, rs1, rs2, '0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, offset);
      default: send(1'b1, e_op_jal, '0, '0, rd, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, offset);
    endcase
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    repeat (n_idle_lp)
      send_idle();
    tests_run++;
    if (errors == test_start_errors)
      $display("Test %s ok", test_name);
    else
      begin
        tests_failed++;
        $display("Test %s FAILED with %0d errors", test_name, errors - test_start_errors);
      end
  endtask

  initial
    begin
      void'($urandom(32'h2227));
      rst_n             = 1'b0;
      dispatch_v        = 1'b0;
      dispatch_op       = e_op_add;
      dispatch_pc       = '0;
      dispatch_rs1      = '0;
      dispatch_rs2      = '0;
      dispatch_imm      = '0;
      dispatch_use_imm  = 1'b0;
      dispatch_rs1_addr = '0;
      dispatch_rs2_addr = '0;
      dispatch_rd_addr  = '0;
      dispatch_rs1_r_v  = 1'b0;
      dispatch_rs2_r_v  = 1'b0;
      dispatch_rd_w_v   = 1'b0;
      dispatch_illegal  = 1'b0;
      for (int i = 0; i < 32; i++)
        begin
          rf[i]         = '0;
          last_wr[i]    = -100;
          busy_until[i] = -100;
        end
      model_init();
      cyc          = 0;
      pc           = 32'h0000_1000;
      last_rd      = '0;
      last_mul_rd  = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (2)
        @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      begin_test("after_reset");
      end_test();

      begin_test("alu_independent");
      repeat (n_alu_lp)
        send_alu(pick_src(6), pick_src(6), 1'b0);
      end_test();

      begin_test("alu_dependent");
      repeat (n_dep_lp)
        send_alu(last_rd, pick_src(0), 1'b0);
      end_test();

      begin_test("mul_chain");
      repeat (n_mul_lp)
        begin
          if ($urandom_range(1, 0))
            send_mul();
          else
            send_alu(pick_src(0), pick_src(0), 1'b0);
        end
      end_test();

      begin_test("branch");
      repeat (n_br_lp)
        send_branch_mix();
      end_test();

      begin_test("illegal");
      repeat (n_exc_lp)
        send_alu(pick_src(0), pick_src(0), $urandom_range(3, 0) == 0);
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
        $display("sim passed");
      else
        $display("sim failed");
      $finish;
    end

endmodule

`default_nettype wire

//--- source/be_calc_top.sv
// Calculator back end top: issue, integer and multiply pipes, exception and completion pipes
`timescale 1ns/1ps
`default_nettype none

module be_calc_top
  import be_calc_pkg::*;
  (input wire              clk_i
   , input wire            rst_n_i

   , input wire            dispatch_v_i
   , input wire calc_op_e  dispatch_op_i
   , input wire vaddr_t    dispatch_pc_i
   , input wire dword_t    dispatch_rs1_i
   , input wire dword_t    dispatch_rs2_i
   , input wire dword_t    dispatch_imm_i
   , input wire            dispatch_use_imm_i
   , input wire reg_addr_t dispatch_rs1_addr_i
   , input wire reg_addr_t dispatch_rs2_addr_i
   , input wire reg_addr_t dispatch_rd_addr_i
   , input wire            dispatch_rs1_r_v_i
   , input wire            dispatch_rs2_r_v_i
   , input wire            dispatch_rd_w_v_i
   , input wire            dispatch_illegal_i

   , output logic          br_v_o
   , output logic          br_taken_o
   , output vaddr_t        br_npc_o

   , output logic          commit_v_o
   , output logic          commit_instret_o
   , output logic          commit_npc_w_v_o
   , output vaddr_t        commit_npc_o
   , output logic          commit_exc_o

   , output logic          iwb_v_o
   , output reg_addr_t     iwb_addr_o
   , output dword_t        iwb_data_o
   );

  logic res_v_lo, res_use_imm_lo;
  calc_op_e res_op_lo;
  vaddr_t res_pc_lo;
  dword_t res_src1_lo, res_src2_lo, res_imm_lo;

  dword_t pipe_int_data_lo, pipe_mul_data_lo;
  logic pipe_int_v_lo, pipe_mul_v_lo, pipe_int_btaken_lo;
  vaddr_t pipe_int_npc_lo;

  logic [comp_stages_lp-1:0] stage_v_lo, comp_rd_w_v_lo;
  reg_addr_t [comp_stages_lp-1:0] comp_rd_addr_lo;
  dword_t [comp_stages_lp-1:0] comp_fwd_data_lo;

  be_calc_issue issue
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .dispatch_v_i(dispatch_v_i), .dispatch_op_i(dispatch_op_i)
     , .dispatch_pc_i(dispatch_pc_i), .dispatch_rs1_i(dispatch_rs1_i)
     , .dispatch_rs2_i(dispatch_rs2_i), .dispatch_imm_i(dispatch_imm_i)
     , .dispatch_use_imm_i(dispatch_use_imm_i)
     , .dispatch_rs1_addr_i(dispatch_rs1_addr_i), .dispatch_rs2_addr_i(dispatch_rs2_addr_i)
     , .dispatch_rs1_r_v_i(dispatch_rs1_r_v_i), .dispatch_rs2_r_v_i(dispatch_rs2_r_v_i)
     , .comp_rd_w_v_i(comp_rd_w_v_lo), .comp_rd_addr_i(comp_rd_addr_lo)
     , .comp_fwd_data_i(comp_fwd_data_lo)
     , .res_v_o(res_v_lo), .res_op_o(res_op_lo), .res_pc_o(res_pc_lo)
     , .res_src1_o(res_src1_lo), .res_src2_o(res_src2_lo), .res_imm_o(res_imm_lo)
     , .res_use_imm_o(res_use_imm_lo)
     );

  // Integer pipe, 1 cycle to stage 1
  be_calc_pipe_int pipe_int
    (.res_v_i(res_v_lo), .res_op_i(res_op_lo), .res_pc_i(res_pc_lo)
     , .res_src1_i(res_src1_lo), .res_src2_i(res_src2_lo), .res_imm_i(res_imm_lo)
     , .res_use_imm_i(res_use_imm_lo)
     , .data_o(pipe_int_data_lo), .v_o(pipe_int_v_lo)
     , .btaken_o(pipe_int_btaken_lo), .npc_o(pipe_int_npc_lo)
     );

  // Multiply pipe, 3 cycles to stage 3
  be_calc_pipe_mul pipe_mul
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(commit_npc_w_v_o)
     , .res_v_i(res_v_lo), .res_op_i(res_op_lo)
     , .res_src1_i(res_src1_lo), .res_src2_i(res_src2_lo)
     , .data_o(pipe_mul_data_lo), .v_o(pipe_mul_v_lo)
     );

  be_calc_exc_pipe exc_pipe
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .dispatch_v_i(dispatch_v_i), .dispatch_illegal_i(dispatch_illegal_i)
     , .dispatch_pc_i(dispatch_pc_i)
     , .int_btaken_i(pipe_int_btaken_lo), .int_npc_i(pipe_int_npc_lo)
     , .stage_v_o(stage_v_lo)
     , .commit_v_o(commit_v_o), .commit_instret_o(commit_instret_o)
     , .commit_npc_w_v_o(commit_npc_w_v_o), .commit_npc_o(commit_npc_o)
     , .commit_exc_o(commit_exc_o)
     , .br_v_o(br_v_o), .br_taken_o(br_taken_o), .br_npc_o(br_npc_o)
     );

  be_calc_comp_pipe comp_pipe
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .dispatch_rd_w_v_i(dispatch_rd_w_v_i), .dispatch_rd_addr_i(dispatch_rd_addr_i)
     , .stage_v_i(stage_v_lo), .instret_i(commit_instret_o)
     , .int_data_i(pipe_int_data_lo), .int_v_i(pipe_int_v_lo)
     , .mul_data_i(pipe_mul_data_lo), .mul_v_i(pipe_mul_v_lo)
     , .rd_w_v_o(comp_rd_w_v_lo), .rd_addr_o(comp_rd_addr_lo)
     , .fwd_data_o(comp_fwd_data_lo)
     , .iwb_v_o(iwb_v_o), .iwb_addr_o(iwb_addr_o), .iwb_data_o(iwb_data_o)
     );

endmodule

`default_nettype wire

//--- source/be_calc_comp_pipe.sv
// Completion stage registers, result merge, bypass data and integer writeback
`timescale 1ns/1ps
`default_nettype none

module be_calc_comp_pipe
  import be_calc_pkg::*;
  (input wire                          clk_i
   , input wire                        rst_n_i

   , input wire                        dispatch_rd_w_v_i
   , input wire reg_addr_t             dispatch_rd_addr_i
   , input wire [comp_stages_lp-1:0]   stage_v_i
   , input wire                        instret_i

   , input wire dword_t                int_data_i
   , input wire                        int_v_i
   , input wire dword_t                mul_data_i
   , input wire                        mul_v_i

   , output logic [comp_stages_lp-1:0] rd_w_v_o
   , output reg_addr_t [comp_stages_lp-1:0] rd_addr_o
   , output dword_t [comp_stages_lp-1:0]    fwd_data_o

   , output logic                      iwb_v_o
   , output reg_addr_t                 iwb_addr_o
   , output dword_t                    iwb_data_o
   );

  logic      [comp_stages_lp:0]   w_v_n;
  reg_addr_t [comp_stages_lp:0]   addr_n;
  dword_t    [comp_stages_lp:0]   data_n;
  logic      [comp_stages_lp-1:0] w_v_r;
  reg_addr_t [comp_stages_lp-1:0] addr_r;
  dword_t    [comp_stages_lp-1:0] data_r;

  // Static latencies mean at most one pipe finishes into a given stage
  always_comb
    begin
      w_v_n  = {w_v_r, dispatch_rd_w_v_i};
      addr_n = {addr_r, dispatch_rd_addr_i};
      data_n = {data_r, 32'b0};

      data_n[1]            |= int_v_i ? int_data_i : '0;
      data_n[mul_stage_lp] |= mul_v_i ? mul_data_i : '0;

      w_v_n[comp_stages_lp-1:0] &= stage_v_i;
      // Write only survives past commit if the instruction retired
      w_v_n[wb_stage_lp]        &= instret_i;
    end

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        w_v_r <= '0;
      else
        w_v_r <= w_v_n[comp_stages_lp-1:0];
    end

  always_ff @(posedge clk_i)
    begin
      addr_r <= addr_n[comp_stages_lp-1:0];
      data_r <= data_n[comp_stages_lp-1:0];
    end

  assign rd_w_v_o   = w_v_r;
  assign rd_addr_o  = addr_r;
  assign fwd_data_o = data_n[comp_stages_lp:1];

  assign iwb_v_o    = w_v_r[wb_stage_lp];
  assign iwb_addr_o = addr_r[wb_stage_lp];
  assign iwb_data_o = data_r[wb_stage_lp];

endmodule

`default_nettype wire

//--- source/be_calc_exc_pipe.sv
// Valid and exception stage registers, branch report, commit and redirect generation
`timescale 1ns/1ps
`default_nettype none

module be_calc_exc_pipe
  import be_calc_pkg::*;
  (input wire                        clk_i
   , input wire                      rst_n_i

   , input wire                      dispatch_v_i
   , input wire                      dispatch_illegal_i
   , input wire vaddr_t              dispatch_pc_i
   , input wire                      int_btaken_i
   , input wire vaddr_t              int_npc_i

   , output logic [comp_stages_lp-1:0] stage_v_o

   , output logic                    commit_v_o
   , output logic                    commit_instret_o
   , output logic                    commit_npc_w_v_o
   , output vaddr_t                  commit_npc_o
   , output logic                    commit_exc_o

   , output logic                    br_v_o
   , output logic                    br_taken_o
   , output vaddr_t                  br_npc_o
   );

  logic [comp_stages_lp-1:0]  v_r, v_n;
  logic [commit_stage_lp:0]   illegal_r;
  vaddr_t [commit_stage_lp:0] pc_r;
  logic [commit_stage_lp:1]   taken_r;
  vaddr_t [commit_stage_lp:1] npc_r;
  logic flush;

  // Stage 0 is the instruction sitting in the reservation register
  assign br_v_o     = v_r[0];
  assign br_taken_o = v_r[0] & int_btaken_i;
  assign br_npc_o   = int_npc_i;

  assign commit_v_o       = v_r[commit_stage_lp];
  assign commit_instret_o = v_r[commit_stage_lp] & ~illegal_r[commit_stage_lp];
  assign commit_exc_o     = v_r[commit_stage_lp] & illegal_r[commit_stage_lp];
  assign commit_npc_w_v_o = v_r[commit_stage_lp]
                            & (illegal_r[commit_stage_lp] | taken_r[commit_stage_lp]);
  // Trap returns to the faulting pc
  assign commit_npc_o     = illegal_r[commit_stage_lp] ? pc_r[commit_stage_lp]
                                                       : npc_r[commit_stage_lp];

  assign flush = commit_npc_w_v_o;

  always_comb
    begin
      v_n = {v_r[comp_stages_lp-2:0], dispatch_v_i};
      // Redirect kills everything younger than the committing instruction
      for (int i = 0; i <= commit_stage_lp; i++)
        v_n[i] = v_n[i] & ~flush;
    end

  assign stage_v_o = v_n;

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        v_r <= '0;
      else
        v_r <= v_n;
    end

  always_ff @(posedge clk_i)
    begin
      illegal_r  <= {illegal_r[commit_stage_lp-1:0], dispatch_illegal_i};
      pc_r       <= {pc_r[commit_stage_lp-1:0], dispatch_pc_i};
      taken_r[1] <= int_btaken_i;
      npc_r[1]   <= int_npc_i;
      for (int i = 2; i <= commit_stage_lp; i++)
        begin
          taken_r[i] <= taken_r[i-1];
          npc_r[i]   <= npc_r[i-1];
        end
    end

endmodule

`default_nettype wire

//--- source/be_calc_pipe_mul.sv
// Two-register multiplier, low word of the product
`timescale 1ns/1ps
`default_nettype none

module be_calc_pipe_mul
  import be_calc_pkg::*;
  (input wire             clk_i
   , input wire           rst_n_i
   , input wire           flush_i

   , input wire           res_v_i
   , input wire calc_op_e res_op_i
   , input wire dword_t   res_src1_i
   , input wire dword_t   res_src2_i

   , output dword_t       data_o
   , output logic         v_o
   );

  dword_t product;
  dword_t data_r;
  logic   v_r;

  assign product = res_src1_i * res_src2_i;

  // Second register holds the committing instruction, so only the first is flushed
  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          v_r <= 1'b0;
          v_o <= 1'b0;
        end
      else
        begin
          v_r <= res_v_i & (res_op_i == e_op_mul) & ~flush_i;
          v_o <= v_r;
        end
    end

  always_ff @(posedge clk_i)
    begin
      data_r <= product;
      data_o <= data_r;
    end

endmodule

`default_nettype wire

//--- source/be_calc_pipe_int.sv
// Integer ALU with branch resolution and next pc
`timescale 1ns/1ps
`default_nettype none

module be_calc_pipe_int
  import be_calc_pkg::*;
  (input wire             res_v_i
   , input wire calc_op_e res_op_i
   , input wire vaddr_t   res_pc_i
   , input wire dword_t   res_src1_i
   , input wire dword_t   res_src2_i
   , input wire dword_t   res_imm_i
   , input wire           res_use_imm_i

   , output dword_t       data_o
   , output logic         v_o
   , output logic         btaken_o
   , output vaddr_t       npc_o
   );

  dword_t op_b;
  vaddr_t pc_plus4;
  logic   src_eq;

  assign op_b     = res_use_imm_i ? res_imm_i : res_src2_i;
  assign pc_plus4 = res_pc_i + 32'd4;
  assign src_eq   = (res_src1_i == res_src2_i);

  always_comb
    begin
      case (res_op_i)
        e_op_add: data_o = res_src1_i + op_b;
        e_op_sub: data_o = res_src1_i - op_b;
        e_op_and: data_o = res_src1_i & op_b;
        e_op_or:  data_o = res_src1_i | op_b;
        e_op_xor: data_o = res_src1_i ^ op_b;
        e_op_sll: data_o = res_src1_i << op_b[4:0];
        e_op_srl: data_o = res_src1_i >> op_b[4:0];
        e_op_slt: data_o = {31'b0, $signed(res_src1_i) < $signed(op_b)};
        // Link address
        e_op_jal: data_o = pc_plus4;
        default:  data_o = '0;
      endcase
    end

  always_comb
    begin
      case (res_op_i)
        e_op_beq: btaken_o = res_v_i & src_eq;
        e_op_bne: btaken_o = res_v_i & ~src_eq;
        e_op_jal: btaken_o = res_v_i;
        default:  btaken_o = 1'b0;
      endcase
    end

  assign npc_o = btaken_o ? res_pc_i + res_imm_i : pc_plus4;

  // Conditional branches write nothing and mul completes later
  assign v_o = res_v_i & ~(res_op_i inside {e_op_mul, e_op_beq, e_op_bne});

endmodule

`default_nettype wire

//--- source/be_calc_issue.sv
// Bypass match, priority operand select and reservation register
`timescale 1ns/1ps
`default_nettype none

module be_calc_issue
  import be_calc_pkg::*;
  (input wire                                   clk_i
   , input wire                                 rst_n_i

   , input wire                                 dispatch_v_i
   , input wire calc_op_e                       dispatch_op_i
   , input wire vaddr_t                         dispatch_pc_i
   , input wire dword_t                         dispatch_rs1_i
   , input wire dword_t                         dispatch_rs2_i
   , input wire dword_t                         dispatch_imm_i
   , input wire                                 dispatch_use_imm_i
   , input wire reg_addr_t                      dispatch_rs1_addr_i
   , input wire reg_addr_t                      dispatch_rs2_addr_i
   , input wire                                 dispatch_rs1_r_v_i
   , input wire                                 dispatch_rs2_r_v_i

   , input wire [comp_stages_lp-1:0]            comp_rd_w_v_i
   , input wire reg_addr_t [comp_stages_lp-1:0] comp_rd_addr_i
   , input wire dword_t [comp_stages_lp-1:0]    comp_fwd_data_i

   , output logic                               res_v_o
   , output calc_op_e                           res_op_o
   , output vaddr_t                             res_pc_o
   , output dword_t                             res_src1_o
   , output dword_t                             res_src2_o
   , output dword_t                             res_imm_o
   , output logic                               res_use_imm_o
   );

  logic [comp_stages_lp-1:0] match_rs1, match_rs2;
  dword_t bypass_rs1, bypass_rs2;

  // x0 never matches and reads as the register file value
  for (genvar i = 0; i < comp_stages_lp; i++)
    begin : fwd_match
      assign match_rs1[i] = dispatch_rs1_r_v_i & comp_rd_w_v_i[i] & (dispatch_rs1_addr_i != '0)
                            & (dispatch_rs1_addr_i == comp_rd_addr_i[i]);
      assign match_rs2[i] = dispatch_rs2_r_v_i & comp_rd_w_v_i[i] & (dispatch_rs2_addr_i != '0)
                            & (dispatch_rs2_addr_i == comp_rd_addr_i[i]);
    end

  // Scan oldest to youngest so the youngest match is the last one kept
  always_comb
    begin
      bypass_rs1 = dispatch_rs1_i;
      bypass_rs2 = dispatch_rs2_i;
      for (int i = comp_stages_lp-1; i >= 0; i--)
        begin
          if (match_rs1[i])
            bypass_rs1 = comp_fwd_data_i[i];
          if (match_rs2[i])
            bypass_rs2 = comp_fwd_data_i[i];
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        res_v_o <= 1'b0;
      else
        res_v_o <= dispatch_v_i;
    end

  always_ff @(posedge clk_i)
    begin
      res_op_o      <= dispatch_op_i;
      res_pc_o      <= dispatch_pc_i;
      res_src1_o    <= bypass_rs1;
      res_src2_o    <= bypass_rs2;
      res_imm_o     <= dispatch_imm_i;
      res_use_imm_o <= dispatch_use_imm_i;
    end

endmodule

`default_nettype wire

//--- source/be_calc_pkg.sv
// Datapath, address and register index types, operation codes, completion stage constants
`default_nettype none

package be_calc_pkg;

  // Completion pipe depth and the stages where results enter or leave it
  localparam int comp_stages_lp  = 5;
  localparam int mul_stage_lp    = 3;
  localparam int wb_stage_lp     = 3;
  localparam int commit_stage_lp = 2;

  typedef logic [31:0] dword_t;
  typedef logic [31:0] vaddr_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [3:0]
  {
    e_op_add = 4'd0
    , e_op_sub = 4'd1
    , e_op_and = 4'd2
    , e_op_or  = 4'd3
    , e_op_xor = 4'd4
    , e_op_sll = 4'd5
    , e_op_srl = 4'd6
    , e_op_slt = 4'd7
    // Goes to the multiply pipe, not the ALU
    , e_op_mul = 4'd8
    , e_op_beq = 4'd9
    , e_op_bne = 4'd10
    , e_op_jal = 4'd11
  } calc_op_e;

endpackage

`default_nettype wire
